// File: src/fc_pkg.sv
package fc_pkg;

    // sram geometry
    localparam int ADDR_W = 16;
    localparam int WORD_W = 32;
    localparam int LANES  = 4;

    // layer shape, 84 inputs packed four per word
    localparam int IN_WORDS  = 21;
    localparam int NUM_OUT   = 10;
    localparam int NUM_PAIRS = 5;
    // 11 two-word steps per row, only word0 valid at the last one
    localparam int LAST_STEP = 10;

    localparam int READ_LATENCY = 3;

    // memory map in words
    localparam int ACT_IN_BASE  = 722;
    localparam int ACT_OUT_BASE = 743;
    localparam int WEIGHT_BASE  = 15540;
    localparam int BIAS_BASE    = 15750;

    // sequencer states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_BIAS  = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    // one sram word, seen as four int8 lanes or a single int32
    typedef union packed {
        // lane 0 sits in the low byte
        logic [LANES-1:0][7:0]    lanes;
        logic signed [WORD_W-1:0] whole;
    } sram_word_u;

endpackage

// File: src/fc_fetch_seq.sv
module fc_fetch_seq
    import fc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic [ADDR_W-1:0] weight_addr0,
    output logic [ADDR_W-1:0] weight_addr1,
    output logic [ADDR_W-1:0] fetch_act_addr0,
    output logic [ADDR_W-1:0] fetch_act_addr1,
    output logic              fetch_issue,
    output logic              bias_issue
);

    logic [1:0] state;
    logic [3:0] step;
    logic [3:0] row;
    logic [2:0] pair;

    logic [ADDR_W-1:0] act_word;
    logic [ADDR_W-1:0] weight_word;
    logic [ADDR_W-1:0] bias_word;

    // word addresses from the memory map
    assign act_word    = ADDR_W'(ACT_IN_BASE + 2 * int'(step));
    assign weight_word = ADDR_W'(WEIGHT_BASE + IN_WORDS * int'(row) + 2 * int'(step));
    assign bias_word   = ADDR_W'(BIAS_BASE + 2 * int'(pair));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            step  <= '0;
            row   <= '0;
            pair  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    // row-major walk, one step per cycle
                    if (step == 4'(LAST_STEP)) begin
                        step <= '0;
                        if (row == 4'(NUM_OUT - 1)) begin
                            row   <= '0;
                            state <= ST_BIAS;
                        end else begin
                            row <= row + 4'd1;
                        end
                    end else begin
                        step <= step + 4'd1;
                    end
                end
                ST_BIAS: begin
                    if (pair == 3'(NUM_PAIRS - 1)) begin
                        pair  <= '0;
                        state <= ST_DONE;
                    end else begin
                        pair <= pair + 3'd1;
                    end
                end
                default: begin
                    // stays here until reset
                    state <= ST_DONE;
                end
            endcase
        end
    end

    always_comb begin
        fetch_issue     = (state == ST_FETCH);
        bias_issue      = (state == ST_BIAS);
        weight_addr0    = '0;
        weight_addr1    = '0;
        fetch_act_addr0 = '0;
        fetch_act_addr1 = '0;
        if (state == ST_FETCH) begin
            weight_addr0    = weight_word;
            weight_addr1    = weight_word + ADDR_W'(1);
            fetch_act_addr0 = act_word;
            fetch_act_addr1 = act_word + ADDR_W'(1);
        end else if (state == ST_BIAS) begin
            // biases share the weight sram
            weight_addr0 = bias_word;
            weight_addr1 = bias_word + ADDR_W'(1);
        end
    end

endmodule

// File: src/fc_mac_bank.sv
module fc_mac_bank
    import fc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_issue,
    input  sram_word_u               weight_rdata0,
    input  sram_word_u               weight_rdata1,
    input  sram_word_u               act_rdata0,
    input  sram_word_u               act_rdata1,
    input  logic [2:0]               rd_pair,
    output logic signed [WORD_W-1:0] acc_lo,
    output logic signed [WORD_W-1:0] acc_hi
);

    logic [READ_LATENCY-1:0]  issue_pipe;
    logic                     data_valid;
    logic [3:0]               step;
    logic [3:0]               row;
    logic                     last_step;
    logic signed [WORD_W-1:0] dot;
    logic signed [WORD_W-1:0] acc [NUM_OUT];

    // issue pulse travels alongside the sram read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_pipe <= '0;
        end else begin
            issue_pipe <= {issue_pipe[READ_LATENCY-2:0], fetch_issue};
        end
    end

    assign data_valid = issue_pipe[READ_LATENCY-1];
    assign last_step  = (step == 4'(LAST_STEP));

    // eight signed products, second pair dropped past the row end
    always_comb begin
        dot = '0;
        for (int i = 0; i < LANES; i++) begin
            dot = dot + $signed(weight_rdata0.lanes[i]) * $signed(act_rdata0.lanes[i]);
            if (!last_step) begin
                dot = dot + $signed(weight_rdata1.lanes[i]) * $signed(act_rdata1.lanes[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step <= '0;
            row  <= '0;
            for (int i = 0; i < NUM_OUT; i++) begin
                acc[i] <= '0;
            end
        end else if (data_valid) begin
            acc[row] <= acc[row] + dot;
            if (last_step) begin
                step <= '0;
                row  <= (row == 4'(NUM_OUT - 1)) ? 4'd0 : row + 4'd1;
            end else begin
                step <= step + 4'd1;
            end
        end
    end

    // pair k maps to accumulators 2k and 2k+1
    assign acc_lo = acc[{rd_pair, 1'b0}];
    assign acc_hi = acc[{rd_pair, 1'b1}];

endmodule

// File: src/fc_bias_writeback.sv
module fc_bias_writeback
    import fc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     bias_issue,
    input  sram_word_u               weight_rdata0,
    input  sram_word_u               weight_rdata1,
    input  logic signed [WORD_W-1:0] acc_lo,
    input  logic signed [WORD_W-1:0] acc_hi,
    input  logic [ADDR_W-1:0]        fetch_act_addr0,
    input  logic [ADDR_W-1:0]        fetch_act_addr1,
    output logic [2:0]               rd_pair,
    output logic                     act_we0,
    output logic                     act_we1,
    output logic [ADDR_W-1:0]        act_addr0,
    output logic [ADDR_W-1:0]        act_addr1,
    output sram_word_u               act_wdata0,
    output sram_word_u               act_wdata1,
    output logic                     finish
);

    logic [READ_LATENCY-1:0] bias_pipe;
    logic                    wr_strobe;
    logic [2:0]              pair;
    logic [1:0]              tail_cnt;
    logic [ADDR_W-1:0]       out_word;

    assign wr_strobe = bias_pipe[READ_LATENCY-1];
    assign rd_pair   = pair;
    assign out_word  = ADDR_W'(ACT_OUT_BASE + 2 * int'(pair));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bias_pipe <= '0;
            pair      <= '0;
            tail_cnt  <= '0;
            finish    <= 1'b0;
        end else begin
            bias_pipe <= {bias_pipe[READ_LATENCY-2:0], bias_issue};
            if (wr_strobe) begin
                pair <= pair + 3'd1;
                if (pair == 3'(NUM_PAIRS - 1)) begin
                    tail_cnt <= 2'd1;
                end
            end else if (tail_cnt == 2'd1) begin
                tail_cnt <= 2'd2;
            end else if (tail_cnt == 2'd2) begin
                // held until reset
                tail_cnt <= 2'd3;
                finish   <= 1'b1;
            end
        end
    end

    // both ports write together, fetch addresses pass through otherwise
    always_comb begin
        act_we0          = wr_strobe;
        act_we1          = wr_strobe;
        act_addr0        = wr_strobe ? out_word : fetch_act_addr0;
        act_addr1        = wr_strobe ? out_word + ADDR_W'(1) : fetch_act_addr1;
        act_wdata0.whole = wr_strobe ? acc_lo + weight_rdata0.whole : '0;
        act_wdata1.whole = wr_strobe ? acc_hi + weight_rdata1.whole : '0;
    end

endmodule

// File: src/fc_layer.sv
module fc_layer
    import fc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              finish,
    output logic [ADDR_W-1:0] weight_addr0,
    output logic [ADDR_W-1:0] weight_addr1,
    input  sram_word_u        weight_rdata0,
    input  sram_word_u        weight_rdata1,
    output logic              act_we0,
    output logic              act_we1,
    output logic [ADDR_W-1:0] act_addr0,
    output logic [ADDR_W-1:0] act_addr1,
    output sram_word_u        act_wdata0,
    output sram_word_u        act_wdata1,
    input  sram_word_u        act_rdata0,
    input  sram_word_u        act_rdata1
);

    logic [ADDR_W-1:0]        fetch_act_addr0;
    logic [ADDR_W-1:0]        fetch_act_addr1;
    logic                     fetch_issue;
    logic                     bias_issue;
    logic [2:0]               rd_pair;
    logic signed [WORD_W-1:0] acc_lo;
    logic signed [WORD_W-1:0] acc_hi;

    fc_fetch_seq fc_fetch_seq_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .weight_addr0    (weight_addr0),
        .weight_addr1    (weight_addr1),
        .fetch_act_addr0 (fetch_act_addr0),
        .fetch_act_addr1 (fetch_act_addr1),
        .fetch_issue     (fetch_issue),
        .bias_issue      (bias_issue)
    );

    fc_mac_bank fc_mac_bank_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_issue   (fetch_issue),
        .weight_rdata0 (weight_rdata0),
        .weight_rdata1 (weight_rdata1),
        .act_rdata0    (act_rdata0),
        .act_rdata1    (act_rdata1),
        .rd_pair       (rd_pair),
        .acc_lo        (acc_lo),
        .acc_hi        (acc_hi)
    );

    fc_bias_writeback fc_bias_writeback_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .bias_issue      (bias_issue),
        .weight_rdata0   (weight_rdata0),
        .weight_rdata1   (weight_rdata1),
        .acc_lo          (acc_lo),
        .acc_hi          (acc_hi),
        .fetch_act_addr0 (fetch_act_addr0),
        .fetch_act_addr1 (fetch_act_addr1),
        .rd_pair         (rd_pair),
        .act_we0         (act_we0),
        .act_we1         (act_we1),
        .act_addr0       (act_addr0),
        .act_addr1       (act_addr1),
        .act_wdata0      (act_wdata0),
        .act_wdata1      (act_wdata1),
        .finish          (finish)
    );

endmodule

// File: tb/fc_checker.sv
module fc_checker
    import fc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              act_we0,
    input  logic [ADDR_W-1:0] act_addr0,
    input  logic [ADDR_W-1:0] act_addr1,
    input  logic [WORD_W-1:0] act_wdata0,
    input  logic [WORD_W-1:0] act_wdata1,
    input  logic              finish,
    input  logic [WORD_W-1:0] expected [NUM_OUT],
    input  logic              report,
    input  int                tb_errors,
    output int                run_writes,
    output int                errors
);

    int total_writes;
    int idx;

    initial begin
        run_writes   = 0;
        total_writes = 0;
        errors       = 0;
    end

    // sampled mid-cycle, away from the edge
    always @(negedge clk) begin
        if (!rst_n) begin
            run_writes = 0;
        end else begin
            if (finish && run_writes < NUM_OUT) begin
                $display("finish is high after only %0d result words", run_writes);
                errors++;
            end
            if (act_we0) begin
                idx = int'(act_addr0) - ACT_OUT_BASE;
                if (idx != run_writes || act_addr1 != act_addr0 + ADDR_W'(1)) begin
                    $display("[FAIL] act_addr0 got %h act_addr1 got %h expected %h %h",
                             act_addr0, act_addr1, ADDR_W'(ACT_OUT_BASE + run_writes),
                             ADDR_W'(ACT_OUT_BASE + run_writes + 1));
                    errors++;
                end
                if (idx >= 0 && idx < NUM_OUT - 1) begin
                    if (act_wdata0 !== expected[idx]) begin
                        $display("[FAIL] act_wdata0 got %h expected %h",
                                 act_wdata0, expected[idx]);
                        errors++;
                    end
                    if (act_wdata1 !== expected[idx+1]) begin
                        $display("[FAIL] act_wdata1 got %h expected %h",
                                 act_wdata1, expected[idx+1]);
                        errors++;
                    end
                end
                run_writes   += 2;
                total_writes += 2;
            end
        end
    end

    always @(posedge report) begin
        $display("result words written %0d, checker errors %0d, testbench errors %0d",
                 total_writes, errors, tb_errors);
    end

endmodule

// File: tb/fc_asserts.sv
module fc_asserts (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic act_we0,
    input logic act_we1,
    input logic finish
);

    logic started;
    int   assert_failures = 0;

    always @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    we_pair_match: assert property (@(posedge clk) disable iff (!rst_n) act_we0 == act_we1)
        else begin
            assert_failures++;
            $error("act_we0 and act_we1 differ");
        end

    finish_held: assert property (@(posedge clk) disable iff (!rst_n) finish |=> finish)
        else begin
            assert_failures++;
            $error("finish fell while out of reset");
        end

    no_early_write: assert property (@(posedge clk) disable iff (!rst_n) act_we0 |-> started)
        else begin
            assert_failures++;
            $error("result write before start");
        end

endmodule

bind fc_layer fc_asserts fc_asserts_i (.*);

// File: tb/tb_fc_layer.sv
module tb_fc_layer
    import fc_pkg::*;
();

    localparam int MEM_WORDS = 16384;
    localparam int TIMEOUT   = 1000;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic              finish;
    logic [ADDR_W-1:0] weight_addr0;
    logic [ADDR_W-1:0] weight_addr1;
    logic [WORD_W-1:0] weight_rdata0;
    logic [WORD_W-1:0] weight_rdata1;
    logic              act_we0;
    logic              act_we1;
    logic [ADDR_W-1:0] act_addr0;
    logic [ADDR_W-1:0] act_addr1;
    logic [WORD_W-1:0] act_wdata0;
    logic [WORD_W-1:0] act_wdata1;
    logic [WORD_W-1:0] act_rdata0;
    logic [WORD_W-1:0] act_rdata1;

    logic [WORD_W-1:0] weight_mem [MEM_WORDS];
    logic [WORD_W-1:0] act_mem [MEM_WORDS];
    logic [WORD_W-1:0] w0_q [READ_LATENCY];
    logic [WORD_W-1:0] w1_q [READ_LATENCY];
    logic [WORD_W-1:0] a0_q [READ_LATENCY];
    logic [WORD_W-1:0] a1_q [READ_LATENCY];
    logic [WORD_W-1:0] input_copy [IN_WORDS];
    logic [WORD_W-1:0] expected [NUM_OUT];
    logic [15:0]       lfsr_state;
    logic              report;
    int                tb_errors;
    int                chk_errors;
    int                run_writes;

    fc_layer fc_layer_i (.*);

    fc_checker fc_checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .act_we0    (act_we0),
        .act_addr0  (act_addr0),
        .act_addr1  (act_addr1),
        .act_wdata0 (act_wdata0),
        .act_wdata1 (act_wdata1),
        .finish     (finish),
        .expected   (expected),
        .report     (report),
        .tb_errors  (tb_errors),
        .run_writes (run_writes),
        .errors     (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // sram models, data three edges after the address
    always @(posedge clk) begin
        w0_q[0] <= weight_mem[weight_addr0[13:0]];
        w1_q[0] <= weight_mem[weight_addr1[13:0]];
        a0_q[0] <= act_mem[act_addr0[13:0]];
        a1_q[0] <= act_mem[act_addr1[13:0]];
        for (int i = 1; i < READ_LATENCY; i++) begin
            w0_q[i] <= w0_q[i-1];
            w1_q[i] <= w1_q[i-1];
            a0_q[i] <= a0_q[i-1];
            a1_q[i] <= a1_q[i-1];
        end
        if (act_we0) begin
            act_mem[act_addr0[13:0]] <= act_wdata0;
        end
        if (act_we1) begin
            act_mem[act_addr1[13:0]] <= act_wdata1;
        end
    end

    assign weight_rdata0 = w0_q[READ_LATENCY-1];
    assign weight_rdata1 = w1_q[READ_LATENCY-1];
    assign act_rdata0    = a0_q[READ_LATENCY-1];
    assign act_rdata1    = a1_q[READ_LATENCY-1];

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [WORD_W-1:0] next_random_word();
        logic [WORD_W-1:0] w;
        logic              fb;
        w = '0;
        for (int i = 0; i < WORD_W; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            w = {w[WORD_W-2:0], fb};
        end
        return w;
    endfunction

    // int8 dot product of row r plus its bias, wrapped to 32 bits
    function automatic logic [WORD_W-1:0] reference_output(int r);
        logic [WORD_W-1:0] wword;
        logic [WORD_W-1:0] aword;
        byte               wb;
        byte               ab;
        int                sum;
        sum = 0;
        for (int i = 0; i < 4 * IN_WORDS; i++) begin
            wword = weight_mem[WEIGHT_BASE + IN_WORDS * r + i / 4];
            aword = act_mem[ACT_IN_BASE + i / 4];
            wb = byte'(wword[8 * (i % 4) +: 8]);
            ab = byte'(aword[8 * (i % 4) +: 8]);
            sum = sum + int'(wb) * int'(ab);
        end
        sum = sum + int'(weight_mem[BIAS_BASE + r]);
        return WORD_W'(sum);
    endfunction

    task automatic fill_background();
        for (int i = 0; i < MEM_WORDS; i++) begin
            weight_mem[i] = WORD_W'(i) * 32'h9e3779b1;
            act_mem[i]    = ~(WORD_W'(i) * 32'h85ebca6b);
        end
        // word past the input vector, must be masked at the last step
        act_mem[ACT_OUT_BASE] = 32'h7f813c55;
    endtask

    task automatic fill_random();
        for (int i = 0; i < IN_WORDS; i++) begin
            act_mem[ACT_IN_BASE + i] = next_random_word();
        end
        // nonzero bytes so a missed mask shows up in the result
        for (int i = 0; i < NUM_OUT * IN_WORDS; i++) begin
            weight_mem[WEIGHT_BASE + i] = next_random_word() | 32'h01010101;
        end
        for (int i = 0; i < NUM_OUT; i++) begin
            weight_mem[BIAS_BASE + i] = next_random_word() | 32'h01010101;
        end
    endtask

    task automatic fill_extreme();
        for (int i = 0; i < IN_WORDS; i++) begin
            act_mem[ACT_IN_BASE + i] = 32'h80808080;
        end
        for (int i = 0; i < NUM_OUT * IN_WORDS; i++) begin
            weight_mem[WEIGHT_BASE + i] = 32'h80808080;
        end
        for (int i = 0; i < NUM_OUT; i++) begin
            weight_mem[BIAS_BASE + i] = 32'h7fffffff;
        end
    endtask

    task automatic run_layer(string name);
        int cycles;
        rst_n = 1'b0;
        start = 1'b0;
        cycles = 0;
        while (cycles < 5) begin
            @(posedge clk);
            cycles++;
        end
        #1 rst_n = 1'b1;
        for (int i = 0; i < NUM_OUT; i++) begin
            expected[i] = reference_output(i);
        end
        for (int i = 0; i < IN_WORDS; i++) begin
            input_copy[i] = act_mem[ACT_IN_BASE + i];
        end
        // idle after reset, nothing may move
        cycles = 0;
        while (cycles < 4) begin
            @(posedge clk);
            if (act_we0 || act_we1 || finish) begin
                $display("%s run: write strobe or finish seen before start", name);
                tb_errors++;
            end
            cycles++;
        end
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        cycles = 0;
        while (!finish && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!finish) begin
            $display("%s run: timeout while waiting for finish", name);
            tb_errors++;
        end
        cycles = 0;
        while (cycles < 5) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (run_writes != NUM_OUT) begin
            $display("%s run: %0d result words written instead of %0d",
                     name, run_writes, NUM_OUT);
            tb_errors++;
        end
        for (int i = 0; i < IN_WORDS; i++) begin
            if (act_mem[ACT_IN_BASE + i] !== input_copy[i]) begin
                $display("[FAIL] act_mem[%0d] got %h expected %h",
                         ACT_IN_BASE + i, act_mem[ACT_IN_BASE + i], input_copy[i]);
                tb_errors++;
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        report     = 1'b0;
        tb_errors  = 0;
        lfsr_state = 16'd62;
        for (int i = 0; i < NUM_OUT; i++) begin
            expected[i] = '0;
        end
        fill_background();
        fill_random();
        run_layer("random");
        fill_background();
        fill_extreme();
        run_layer("extreme");
        tb_errors += fc_layer_i.fc_asserts_i.assert_failures;
        report = 1'b1;
        #1;
        if (tb_errors == 0 && chk_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: compile.f
src/fc_pkg.sv
src/fc_fetch_seq.sv
src/fc_mac_bank.sv
src/fc_bias_writeback.sv
src/fc_layer.sv
tb/fc_checker.sv
tb/fc_asserts.sv
tb/tb_fc_layer.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --assert -j 0 --top-module tb_fc_layer -f compile.f -o sim
	./obj_dir/sim | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only -Wall --top-module tb_fc_layer --timing -f compile.f

clean:
	rm -rf obj_dir sim.log
